/* Makefile */
TOP = fm_demod_tb
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f filelist.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) > $(LOG) 2>&1 || echo "Test failures found" >> $(LOG)
	cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* filelist.f */
source/fm_pkg.sv
source/sample_fifo.sv
source/divider.sv
source/qarctan.sv
source/demodulate.sv
source/fm_demod_top.sv
verification/fm_demod_checker.sv
verification/fm_demod_tb.sv

/* source/demodulate.sv */
// Conjugate-multiply discriminator stage; reads samples, runs qarctan, writes scaled angles.
`timescale 1ns/1ps

module demodulate #(
    parameter int DATA_WIDTH = fm_pkg::DATA_WIDTH,
    parameter int QUANT_BITS = fm_pkg::QUANT_BITS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fifo_empty,
    output logic                  fifo_rd_en,
    input  logic [DATA_WIDTH-1:0] real_in,
    input  logic [DATA_WIDTH-1:0] imag_in,
    output logic [DATA_WIDTH-1:0] demod_out,
    output logic                  wr_en,
    input  logic                  out_full
);

    localparam logic signed [DATA_WIDTH-1:0] GAIN_W    = DATA_WIDTH'(fm_pkg::GAIN);
    localparam logic        [DATA_WIDTH-1:0] STARTUP_W = DATA_WIDTH'(fm_pkg::STARTUP_OUT);

    fm_pkg::demod_state_t           state;
    logic [DATA_WIDTH-1:0]          real_curr;
    logic [DATA_WIDTH-1:0]          imag_curr;
    logic [DATA_WIDTH-1:0]          real_prev;
    logic [DATA_WIDTH-1:0]          imag_prev;
    logic signed [2*DATA_WIDTH-1:0] rr;
    logic signed [2*DATA_WIDTH-1:0] ii;
    logic signed [2*DATA_WIDTH-1:0] ri;
    logic signed [2*DATA_WIDTH-1:0] ir;
    logic signed [2*DATA_WIDTH-1:0] gained;
    logic [DATA_WIDTH-1:0]          x_sum;
    logic [DATA_WIDTH-1:0]          y_diff;
    logic [DATA_WIDTH-1:0]          x;
    logic [DATA_WIDTH-1:0]          y;
    logic [DATA_WIDTH-1:0]          angle;
    logic [DATA_WIDTH-1:0]          result;
    logic                           arc_start;
    logic                           arc_done;

    qarctan #(
        .DATA_WIDTH(DATA_WIDTH),
        .QUANT_BITS(QUANT_BITS)
    ) u_qarctan (
        .clk      (clk),
        .reset    (reset),
        .arc_start(arc_start),
        .x        (x),
        .y        (y),
        .angle    (angle),
        .arc_done (arc_done)
    );

    // Conjugate product --------------------
    // curr * conj(prev); products keep their low DATA_WIDTH bits before the sum.
    always_comb begin
        rr     = $signed(real_prev) * $signed(real_curr);
        ii     = $signed(imag_prev) * $signed(imag_curr);
        ri     = $signed(real_prev) * $signed(imag_curr);
        ir     = $signed(imag_prev) * $signed(real_curr);
        x_sum  = rr[DATA_WIDTH-1:0] + ii[DATA_WIDTH-1:0];
        y_diff = ri[DATA_WIDTH-1:0] - ir[DATA_WIDTH-1:0];
        x      = fm_pkg::dequantize(x_sum, QUANT_BITS);
        y      = fm_pkg::dequantize(y_diff, QUANT_BITS);
        gained = $signed(angle) * GAIN_W;
    end

    // Sample is taken in the same cycle as the read strobe.
    assign fifo_rd_en = !fifo_empty
                      && (state == fm_pkg::FIRST_WAIT || state == fm_pkg::IDLE);
    assign wr_en      = (state == fm_pkg::OUTPUT) && !out_full;
    assign demod_out  = result;

    // Sequencer --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= fm_pkg::FIRST_WAIT;
            arc_start <= 1'b0;
        end else begin
            arc_start <= 1'b0;
            case (state)
                fm_pkg::FIRST_WAIT: begin
                    if (!fifo_empty) begin
                        state <= fm_pkg::OUTPUT;  // No predecessor so emit the start-up word.
                    end
                end
                fm_pkg::IDLE: begin
                    if (!fifo_empty) begin
                        arc_start <= 1'b1;
                        state     <= fm_pkg::WAITING;
                    end
                end
                fm_pkg::WAITING: begin
                    if (arc_done) begin
                        state <= fm_pkg::OUTPUT;
                    end
                end
                fm_pkg::OUTPUT: begin
                    if (!out_full) begin
                        state <= fm_pkg::IDLE;  // Holds here under back-pressure.
                    end
                end
                default: state <= fm_pkg::FIRST_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            real_prev <= real_curr;
            imag_prev <= imag_curr;
            real_curr <= real_in;
            imag_curr <= imag_in;
        end
        if (state == fm_pkg::FIRST_WAIT && fifo_rd_en) begin
            result <= STARTUP_W;
        end else if (state == fm_pkg::WAITING && arc_done) begin
            result <= fm_pkg::dequantize(gained[DATA_WIDTH-1:0], QUANT_BITS);
        end
    end

endmodule

/* source/divider.sv */
// Iterative signed restoring divider; one quotient bit per cycle, done DATA_WIDTH+1 after start.
`timescale 1ns/1ps

module divider #(
    parameter int DATA_WIDTH = fm_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  div_start,
    input  logic [DATA_WIDTH-1:0] dividend,
    input  logic [DATA_WIDTH-1:0] divisor,
    output logic [DATA_WIDTH-1:0] quotient,
    output logic                  div_done
);

    localparam int CNT_W = $clog2(DATA_WIDTH);

    fm_pkg::divider_state_t state;
    logic [CNT_W-1:0]       count;
    logic [DATA_WIDTH-1:0]  work;  // Dividend bits shift out, quotient bits shift in.
    logic [DATA_WIDTH-1:0]  rem;
    logic [DATA_WIDTH-1:0]  dsr;
    logic                   neg;
    logic [DATA_WIDTH+1:0]  trial;

    // Restoring step --------------------
    assign trial = {1'b0, rem, work[DATA_WIDTH-1]} - {2'b00, dsr};

    // Sign goes back on at the end. Magnitudes truncate toward zero.
    assign quotient = neg ? -work : work;
    assign div_done = (state == fm_pkg::DIV_DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= fm_pkg::DIV_IDLE;
            count <= '0;
        end else begin
            case (state)
                fm_pkg::DIV_IDLE: begin
                    if (div_start) begin
                        state <= fm_pkg::DIV_RUN;
                        count <= '0;
                    end
                end
                fm_pkg::DIV_RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(DATA_WIDTH - 1)) begin
                        state <= fm_pkg::DIV_DONE;
                    end
                end
                fm_pkg::DIV_DONE: state <= fm_pkg::DIV_IDLE;
                default:          state <= fm_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fm_pkg::DIV_IDLE && div_start) begin
            work <= dividend[DATA_WIDTH-1] ? -dividend : dividend;
            dsr  <= divisor[DATA_WIDTH-1] ? -divisor : divisor;
            rem  <= '0;
            neg  <= dividend[DATA_WIDTH-1] ^ divisor[DATA_WIDTH-1];
        end else if (state == fm_pkg::DIV_RUN) begin
            if (trial[DATA_WIDTH+1]) begin
                // Trial went negative, keep the shifted remainder.
                rem  <= {rem[DATA_WIDTH-2:0], work[DATA_WIDTH-1]};
                work <= {work[DATA_WIDTH-2:0], 1'b0};
            end else begin
                rem  <= trial[DATA_WIDTH-1:0];
                work <= {work[DATA_WIDTH-2:0], 1'b1};
            end
        end
    end

endmodule

/* source/fm_demod_top.sv */
// FM discriminator core top; input FIFO, demodulator and output FIFO chained in series.
`timescale 1ns/1ps

module fm_demod_top #(
    parameter int DATA_WIDTH = fm_pkg::DATA_WIDTH,
    parameter int QUANT_BITS = fm_pkg::QUANT_BITS,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_wr_en,
    input  logic [DATA_WIDTH-1:0] in_real,
    input  logic [DATA_WIDTH-1:0] in_imag,
    output logic                  in_full,
    input  logic                  out_rd_en,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_empty
);

    logic [2*DATA_WIDTH-1:0] head_sample;  // {real, imag}.
    logic                    fifo_empty;
    logic                    fifo_rd_en;
    logic [DATA_WIDTH-1:0]   demod_out;
    logic                    demod_wr_en;
    logic                    out_full;

    sample_fifo #(
        .DATA_WIDTH(2 * DATA_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_in_fifo (
        .clk  (clk),
        .reset(reset),
        .wr_en(in_wr_en),
        .din  ({in_real, in_imag}),
        .full (in_full),
        .rd_en(fifo_rd_en),
        .dout (head_sample),
        .empty(fifo_empty)
    );

    demodulate #(
        .DATA_WIDTH(DATA_WIDTH),
        .QUANT_BITS(QUANT_BITS)
    ) u_demodulate (
        .clk       (clk),
        .reset     (reset),
        .fifo_empty(fifo_empty),
        .fifo_rd_en(fifo_rd_en),
        .real_in   (head_sample[2*DATA_WIDTH-1:DATA_WIDTH]),
        .imag_in   (head_sample[DATA_WIDTH-1:0]),
        .demod_out (demod_out),
        .wr_en     (demod_wr_en),
        .out_full  (out_full)
    );

    sample_fifo #(
        .DATA_WIDTH(DATA_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_out_fifo (
        .clk  (clk),
        .reset(reset),
        .wr_en(demod_wr_en),
        .din  (demod_out),
        .full (out_full),
        .rd_en(out_rd_en),
        .dout (out_data),
        .empty(out_empty)
    );

endmodule

/* source/fm_pkg.sv */
// Shared widths, fixed-point constants, FSM states and quantize helpers for the discriminator.
package fm_pkg;

    // Datapath defaults --------------------
    parameter int DATA_WIDTH = 32;
    parameter int QUANT_BITS = 10;

    localparam logic [31:0] GAIN        = 32'h0000_02F6; // Discriminator gain.
    localparam logic [31:0] STARTUP_OUT = 32'h0000_04A6; // Word for the first sample.
    localparam logic [31:0] QUAD1       = 32'd804;       // pi/4 in Q10.
    localparam logic [31:0] QUAD3       = 32'd2412;      // 3*pi/4 in Q10.

    // FSM states --------------------
    typedef enum logic [2:0] {FIRST_WAIT, IDLE, WAITING, OUTPUT} demod_state_t;
    typedef enum logic [1:0] {ARC_IDLE, ARC_DIVIDE, ARC_FINISH} qarctan_state_t;
    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} divider_state_t;

    // Fixed-point helpers --------------------
    // Divide by 2**bits, rounding toward zero like a signed divide.
    function automatic logic signed [DATA_WIDTH-1:0] dequantize(
        input logic signed [DATA_WIDTH-1:0] value,
        input int                           bits = QUANT_BITS
    );
        logic [DATA_WIDTH-1:0] mag;
        logic [DATA_WIDTH-1:0] res;
        mag = value[DATA_WIDTH-1] ? -value : value;
        res = mag >> bits;
        return value[DATA_WIDTH-1] ? -res : res;
    endfunction

    function automatic logic signed [DATA_WIDTH-1:0] quantize(
        input logic signed [DATA_WIDTH-1:0] value,
        input int                           bits = QUANT_BITS
    );
        return value <<< bits;
    endfunction

endpackage

/* source/qarctan.sv */
// Quadrant arctangent; turns (x, y) into a Q10 angle, arc_done DATA_WIDTH+3 after arc_start.
`timescale 1ns/1ps

module qarctan #(
    parameter int DATA_WIDTH = fm_pkg::DATA_WIDTH,
    parameter int QUANT_BITS = fm_pkg::QUANT_BITS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  arc_start,
    input  logic [DATA_WIDTH-1:0] x,
    input  logic [DATA_WIDTH-1:0] y,
    output logic [DATA_WIDTH-1:0] angle,
    output logic                  arc_done
);

    localparam logic signed [DATA_WIDTH-1:0] QUAD1_W = DATA_WIDTH'(fm_pkg::QUAD1);
    localparam logic signed [DATA_WIDTH-1:0] QUAD3_W = DATA_WIDTH'(fm_pkg::QUAD3);

    fm_pkg::qarctan_state_t  state;
    logic [DATA_WIDTH-1:0]   abs_y;
    logic [DATA_WIDTH-1:0]   dividend_c;
    logic [DATA_WIDTH-1:0]   divisor_c;
    logic [DATA_WIDTH-1:0]   div_dividend;
    logic [DATA_WIDTH-1:0]   div_divisor;
    logic [DATA_WIDTH-1:0]   quotient;
    logic                    div_start;
    logic                    div_done;
    logic                    x_neg;
    logic                    y_neg;
    logic signed [2*DATA_WIDTH-1:0] scaled;
    logic [DATA_WIDTH-1:0]   angle_c;

    divider #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_divider (
        .clk      (clk),
        .reset    (reset),
        .div_start(div_start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .quotient (quotient),
        .div_done (div_done)
    );

    // Ratio --------------------
    // The +1 on |y| keeps the divisor away from zero.
    always_comb begin
        abs_y = (y[DATA_WIDTH-1] ? -y : y) + 1'b1;
        if (x[DATA_WIDTH-1]) begin
            dividend_c = fm_pkg::quantize(x + abs_y, QUANT_BITS);
            divisor_c  = abs_y - x;
        end else begin
            dividend_c = fm_pkg::quantize(x - abs_y, QUANT_BITS);
            divisor_c  = x + abs_y;
        end
    end

    // Angle from the ratio, mirrored for negative y.
    always_comb begin
        scaled  = QUAD1_W * $signed(quotient);
        angle_c = (x_neg ? QUAD3_W : QUAD1_W)
                - fm_pkg::dequantize(scaled[DATA_WIDTH-1:0], QUANT_BITS);
        if (y_neg) begin
            angle_c = -angle_c;
        end
    end

    assign arc_done = (state == fm_pkg::ARC_FINISH);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= fm_pkg::ARC_IDLE;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                fm_pkg::ARC_IDLE: begin
                    if (arc_start) begin
                        div_start <= 1'b1;
                        state     <= fm_pkg::ARC_DIVIDE;
                    end
                end
                fm_pkg::ARC_DIVIDE: begin
                    if (div_done) begin
                        state <= fm_pkg::ARC_FINISH;
                    end
                end
                fm_pkg::ARC_FINISH: state <= fm_pkg::ARC_IDLE;
                default:            state <= fm_pkg::ARC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fm_pkg::ARC_IDLE && arc_start) begin
            div_dividend <= dividend_c;
            div_divisor  <= divisor_c;
            x_neg        <= x[DATA_WIDTH-1];
            y_neg        <= y[DATA_WIDTH-1];
        end
        if (state == fm_pkg::ARC_DIVIDE && div_done) begin
            angle <= angle_c;
        end
    end

endmodule

/* source/sample_fifo.sv */
// Show-ahead synchronous FIFO; dout shows the head word while empty is low.
`timescale 1ns/1ps

module sample_fifo #(
    parameter int DATA_WIDTH = fm_pkg::DATA_WIDTH,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] din,
    output logic                  full,
    input  logic                  rd_en,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_wr;
    logic                  do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;  // Writes while full are dropped.
    assign do_rd = rd_en && !empty;
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verification/fm_demod_checker.sv */
// Bound assertions on FIFO strobes and qarctan latency, attached to demodulate and sample_fifo.
`timescale 1ns/1ps

module fm_demod_checker #(
    parameter int DATA_WIDTH = fm_pkg::DATA_WIDTH
) (
    input logic clk,
    input logic reset,
    input logic wr_en,
    input logic full,
    input logic rd_en,
    input logic empty,
    input logic arc_start,
    input logic arc_done
);

    no_write_when_full: assert property (@(posedge clk) disable iff (reset) !(wr_en && full))
        else $error("Write strobe while the FIFO is full.");

    no_read_when_empty: assert property (@(posedge clk) disable iff (reset) !(rd_en && empty))
        else $error("Read strobe while the FIFO is empty.");

    // Done must trail its start by the fixed arctangent latency.
    arc_latency: assert property (@(posedge clk) disable iff (reset)
        arc_done |-> $past(arc_start, DATA_WIDTH + 3))
        else $error("arc_done without arc_start DATA_WIDTH+3 cycles earlier.");

endmodule

bind demodulate fm_demod_checker #(.DATA_WIDTH(DATA_WIDTH)) u_demod_checker (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (wr_en),
    .full     (out_full),
    .rd_en    (fifo_rd_en),
    .empty    (fifo_empty),
    .arc_start(arc_start),
    .arc_done (arc_done)
);

bind sample_fifo fm_demod_checker u_fifo_checker (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (wr_en),
    .full     (full),
    .rd_en    (rd_en),
    .empty    (empty),
    .arc_start(1'b0),
    .arc_done (1'b0)
);

/* verification/fm_demod_tb.sv */
// Table-driven testbench for the FM discriminator core; checks every output word against a model.
`timescale 1ns/1ps

module fm_demod_tb;

    localparam int DATA_WIDTH = fm_pkg::DATA_WIDTH;
    localparam int QUANT_BITS = fm_pkg::QUANT_BITS;
    localparam int FIFO_DEPTH = 16;

    localparam int KIND_CONST  = 0;
    localparam int KIND_ROTATE = 1;
    localparam int KIND_RANDOM = 2;

    localparam int STALL_NONE   = 0;
    localparam int STALL_FILL   = 1;
    localparam int STALL_RANDOM = 2;

    // Unit circle at 45 degree steps with amplitude 1000.
    localparam int UNIT_RE [8] = '{1000, 707, 0, -707, -1000, -707, 0, 707};
    localparam int UNIT_IM [8] = '{0, 707, 1000, 707, 0, -707, -1000, -707};

    typedef struct {
        string name;
        int    kind;
        int    count;
        int    step;
        int    stall;
    } test_row_t;

    logic                  clk;
    logic                  reset;
    logic                  in_wr_en;
    logic [DATA_WIDTH-1:0] in_real;
    logic [DATA_WIDTH-1:0] in_imag;
    logic                  in_full;
    logic                  out_rd_en;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_empty;

    test_row_t             rows [$];
    int                    smp_re [$];
    int                    smp_im [$];
    logic [DATA_WIDTH-1:0] exp_q [$];
    int                    wr_idx;
    int                    checks;
    int                    errors;

    fm_demod_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .QUANT_BITS(QUANT_BITS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .in_wr_en (in_wr_en),
        .in_real  (in_real),
        .in_imag  (in_imag),
        .in_full  (in_full),
        .out_rd_en(out_rd_en),
        .out_data (out_data),
        .out_empty(out_empty)
    );

    always #5 clk = ~clk;

    // Reference model --------------------
    // One output word from the previous and current sample.
    function automatic logic [DATA_WIDTH-1:0] model_word(int pr, int pi, int cr, int ci);
        int x;
        int y;
        int abs_y;
        int num;
        int den;
        int base;
        int ratio;
        int angle;
        x     = fm_pkg::dequantize(pr * cr + pi * ci);
        y     = fm_pkg::dequantize(pr * ci - pi * cr);
        abs_y = ((y < 0) ? -y : y) + 1;
        if (x >= 0) begin
            num  = (x - abs_y) <<< QUANT_BITS;
            den  = x + abs_y;
            base = int'(fm_pkg::QUAD1);
        end else begin
            num  = (x + abs_y) <<< QUANT_BITS;
            den  = abs_y - x;
            base = int'(fm_pkg::QUAD3);
        end
        ratio = num / den;  // Truncates toward zero.
        angle = base - fm_pkg::dequantize(int'(fm_pkg::QUAD1) * ratio);
        if (y < 0) begin
            angle = -angle;
        end
        return fm_pkg::dequantize(angle * int'(fm_pkg::GAIN));
    endfunction

    // Compare tasks --------------------
    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Stimulus table --------------------
    task automatic add_row(input string name, input int kind, input int count,
                           input int step, input int stall);
        test_row_t row;
        row.name  = name;
        row.kind  = kind;
        row.count = count;
        row.step  = step;
        row.stall = stall;
        rows.push_back(row);
    endtask

    task automatic load_table();
        add_row("startup",      KIND_CONST,  1,   0, STALL_NONE);
        add_row("const_phase",  KIND_CONST,  12,  0, STALL_NONE);
        add_row("rotate_q1",    KIND_ROTATE, 12,  1, STALL_NONE);  // +45 deg.
        add_row("rotate_90",    KIND_ROTATE, 10,  2, STALL_NONE);
        add_row("rotate_q2",    KIND_ROTATE, 12,  3, STALL_NONE);  // Negative x.
        add_row("rotate_q3",    KIND_ROTATE, 12,  5, STALL_NONE);  // Negative x and y.
        add_row("rotate_q4",    KIND_ROTATE, 12,  7, STALL_NONE);  // Negative y.
        add_row("backpressure", KIND_ROTATE, 40,  1, STALL_FILL);
        add_row("random_long",  KIND_RANDOM, 200, 0, STALL_RANDOM);
    endtask

    task automatic build_row(input test_row_t row);
        int i;
        int idx;
        smp_re.delete();
        smp_im.delete();
        exp_q.delete();
        for (i = 0; i < row.count; i++) begin
            if (row.kind == KIND_RANDOM) begin
                smp_re.push_back(int'($urandom % 4096) - 2048);
                smp_im.push_back(int'($urandom % 4096) - 2048);
            end else begin
                idx = (row.kind == KIND_CONST) ? 1 : (i * row.step) % 8;
                smp_re.push_back(UNIT_RE[idx]);
                smp_im.push_back(UNIT_IM[idx]);
            end
        end
        exp_q.push_back(fm_pkg::STARTUP_OUT);  // First sample has no predecessor.
        for (i = 1; i < row.count; i++) begin
            exp_q.push_back(model_word(smp_re[i-1], smp_im[i-1], smp_re[i], smp_im[i]));
        end
    endtask

    // Drivers --------------------
    task automatic apply_reset();
        @(negedge clk);
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        out_rd_en = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic write_samples();
        while (wr_idx < smp_re.size()) begin
            @(negedge clk);
            if (!in_full) begin
                in_wr_en = 1'b1;
                in_real  = smp_re[wr_idx];
                in_imag  = smp_im[wr_idx];
                wr_idx++;
            end else begin
                in_wr_en = 1'b0;
            end
        end
        @(negedge clk);
        in_wr_en = 1'b0;
    endtask

    task automatic read_words(input string name, input int stall);
        int got;
        logic take;
        got = 0;
        if (stall == STALL_FILL) begin
            // Both FIFOs full plus one result parked in the demodulator.
            while (!(in_full && wr_idx == 2 * FIFO_DEPTH + 1)) begin
                @(negedge clk);
            end
            repeat (DATA_WIDTH + 20) @(negedge clk);
            check_flag({name, " in_full held"}, 1'b1, in_full);
            check_flag({name, " out_empty held"}, 1'b0, out_empty);
            check_word({name, " samples accepted"}, DATA_WIDTH'(2 * FIFO_DEPTH + 1),
                       DATA_WIDTH'(wr_idx));
        end
        while (got < exp_q.size()) begin
            @(negedge clk);
            take = (stall == STALL_RANDOM) ? (($urandom % 4) != 0) : 1'b1;
            if (take && !out_empty) begin
                out_rd_en = 1'b1;
                check_word($sformatf("%s word %0d", name, got), exp_q[got], out_data);
                got++;
            end else begin
                out_rd_en = 1'b0;
            end
        end
        @(negedge clk);
        out_rd_en = 1'b0;
        check_flag({name, " drained"}, 1'b1, out_empty);
    endtask

    task automatic run_row(input test_row_t row);
        build_row(row);
        apply_reset();
        check_flag({row.name, " out_empty after reset"}, 1'b1, out_empty);
        check_flag({row.name, " in_full after reset"}, 1'b0, in_full);
        wr_idx = 0;
        fork
            write_samples();
            read_words(row.name, row.stall);
        join
    endtask

    // Main sequence --------------------
    initial begin
        int     total;
        int     r;
        longint limit_ns;
        clk       = 1'b0;
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        in_real   = '0;
        in_imag   = '0;
        out_rd_en = 1'b0;
        wr_idx    = 0;
        checks    = 0;
        errors    = 0;
        void'($urandom(79));
        load_table();
        total = 0;
        for (r = 0; r < rows.size(); r++) begin
            total += rows[r].count;
        end
        limit_ns = longint'(total) * (DATA_WIDTH + 20) * 10 * 4;
        fork
            begin
                #(limit_ns);
                $display("Timeout: run did not finish within %0d ns", limit_ns);
                $display("Checks: %0d, errors: %0d", checks, errors);
                $display("Test failures found");
                $finish;
            end
        join_none
        for (r = 0; r < rows.size(); r++) begin
            run_row(rows[r]);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
